/* all.f */
+incdir+source
source/fe_isa_pkg.sv
source/fe_pipe_pkg.sv
source/fe_ctrl.sv
source/fe_pcgen.sv
source/fe_align.sv
source/fe_decoder.sv
source/fe_pkg_fifo.sv
source/frontend.sv
dv/frontend_tb.sv

/* dv/frontend_tb.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module frontend_tb;
  import fe_isa_pkg::*;
  import fe_pipe_pkg::*;

  typedef enum int {
    RDY_ALWAYS,
    RDY_RANDOM,
    RDY_HOLD
  } ready_mode_e;

  // target zero means no redirect
  // idle cycles run with ready low first
  typedef struct {
    string       name;
    logic [31:0] target;
    int          count;
    ready_mode_e mode;
    int          idle;
  } row_t;

  localparam int NUM_ROWS    = 7;
  localparam int HOLD_CYCLES = 20;

  logic                      clk;
  logic                      arst_n_i;
  redirect_t                 redirect;
  logic                      imem_req;
  logic [31:0]               imem_addr;
  logic [63:0]               imem_rdata;
  logic                      pkg_valid;
  logic                      pkg_ready;
  logic [1:0]                pkg_mask;
  pipeline_ctrl_pack_t [1:0] pkg;

  logic [31:0] prog [256];
  fe_op_e      prog_op [256];
  fe_op_e      kind_op [9] = '{OP_ADD_W, OP_SUB_W, OP_ADDI_W, OP_LU12I_W, OP_LD_W,
                               OP_ST_W, OP_BEQ, OP_BL, OP_JIRL};
  row_t        rows [NUM_ROWS];
  logic        req_s;
  logic [31:0] addr_s;
  logic [31:0] model_pc;
  int          checks;
  int          errors;

  frontend i_frontend (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .redirect_i   (redirect),
    .imem_req_o   (imem_req),
    .imem_addr_o  (imem_addr),
    .imem_rdata_i (imem_rdata),
    .pkg_valid_o  (pkg_valid),
    .pkg_ready_i  (pkg_ready),
    .pkg_mask_o   (pkg_mask),
    .pkg_o        (pkg)
  );

  always #50 clk = ~clk;

  // data follows the fetch strobe by one cycle
  always @(negedge clk)
  begin
    req_s  = imem_req;
    addr_s = imem_addr;
  end

  always @(posedge clk)
  begin
    if (req_s)
    begin
      #1;
      imem_rdata = {prog[{addr_s[9:3], 1'b1}], prog[{addr_s[9:3], 1'b0}]};
    end
  end

  task automatic load_program;
    logic [7:0] a;
    logic [4:0] rd;
    logic [4:0] rj;
    logic [4:0] rk;
    for (int i = 0; i < 256; i++)
    begin
      a  = 8'(i);
      rd = a[4:0];
      rj = a[7:3];
      rk = {a[2:0], a[7:6]};
      case (i % 9)
        0: prog[i] = {17'h00020, rk, rj, rd};
        1: prog[i] = {17'h00022, rk, rj, rd};
        2: prog[i] = {10'h00a, a, 4'h5, rj, rd};
        3: prog[i] = {7'h0a, a, 12'h123, rd};
        4: prog[i] = {10'h0a2, 4'h3, a, rj, rd};
        5: prog[i] = {10'h0a6, a, 4'hc, rj, rd};
        6: prog[i] = {6'h16, a, ~a, rj, rd};
        7: prog[i] = {6'h15, a, a, a, 2'b01};
        default: prog[i] = {6'h13, ~a, a, rj, rd};
      endcase
      prog_op[i] = kind_op[i % 9];
    end
    // two words outside the subset
    prog[5]     = 32'h0000_0000;
    prog_op[5]  = OP_INE;
    prog[10]    = 32'hfc00_000a;
    prog_op[10] = OP_INE;
  endtask

  task automatic fill_table;
    rows[0] = '{"reset_stream", 32'h0, 12, RDY_ALWAYS, 0};
    rows[1] = '{"random_ready", 32'h0, 16, RDY_RANDOM, 0};
    rows[2] = '{"redirect_upper", 32'h1c000104, 10, RDY_ALWAYS, 0};
    rows[3] = '{"hold_ready", 32'h0, 14, RDY_HOLD, 0};
    rows[4] = '{"redirect_inflight", 32'h1c000244, 10, RDY_RANDOM, 2};
    rows[5] = '{"redirect_full", 32'h1c00008c, 12, RDY_ALWAYS, 8};
    rows[6] = '{"beq_target", 32'h1c000300, 10, RDY_HOLD, 0};
  endtask

  // expected slot from the opcode and register rules
  function automatic pipeline_ctrl_pack_t expect_slot(input logic [31:0] pc);
    pipeline_ctrl_pack_t s;
    logic [31:0]         w;
    w       = prog[pc[9:2]];
    s       = '0;
    s.pc    = pc;
    s.di.op = prog_op[pc[9:2]];
    case (s.di.op)
      OP_ADD_W, OP_SUB_W:
        s.di = '{s.di.op, R0_RK, R1_RJ, W_RD};
      OP_ADDI_W, OP_LD_W, OP_JIRL:
        s.di = '{s.di.op, R0_NONE, R1_RJ, W_RD};
      OP_LU12I_W:
        s.di = '{s.di.op, R0_NONE, R1_NONE, W_RD};
      OP_ST_W, OP_BEQ:
        s.di = '{s.di.op, R0_RD, R1_RJ, W_NONE};
      OP_BL:
        s.di = '{s.di.op, R0_NONE, R1_NONE, W_R1};
      default:
        s.di = '{OP_INE, R0_NONE, R1_NONE, W_NONE};
    endcase
    if (s.di.r0_sel == R0_RK)
      s.ri.r_reg[0] = w[14:10];
    if (s.di.r0_sel == R0_RD)
      s.ri.r_reg[0] = w[4:0];
    if (s.di.r1_sel == R1_RJ)
      s.ri.r_reg[1] = w[9:5];
    if (s.di.w_sel == W_RD)
      s.ri.w_reg = w[4:0];
    if (s.di.w_sel == W_R1)
      s.ri.w_reg = 5'd1;
    s.ine = (s.di.op == OP_INE);
    return s;
  endfunction

  function automatic fe_pkt_t expect_pkt(input logic [31:0] pc);
    fe_pkt_t p;
    p      = '0;
    p.mask = pc[2] ? 2'b01 : 2'b11;
    p.p[0] = expect_slot(pc);
    if (!pc[2])
      p.p[1] = expect_slot(pc + 32'd4);
    return p;
  endfunction

  task automatic check_mask(input string name, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("mismatch %s mask expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("mismatch %s fetch address expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_pkt(input string name, input fe_pkt_t exp, input fe_pkt_t act);
    for (int i = 0; i < 2; i++)
    begin
      if (exp.mask[i])
      begin
        checks++;
        if (act.p[i] !== exp.p[i])
        begin
          errors++;
          $display("mismatch %s slot %0d expected %h actual %h", name, i, exp.p[i], act.p[i]);
        end
      end
    end
  endtask

  task automatic run_row(input row_t r);
    int      got;
    int      cyc;
    int      err_start;
    fe_pkt_t exp;
    fe_pkt_t act;
    got       = 0;
    cyc       = 0;
    err_start = errors;
    repeat (r.idle)
    begin
      @(posedge clk);
      #1;
      pkg_ready = 1'b0;
    end
    if (r.target != '0)
    begin
      @(posedge clk);
      #1;
      pkg_ready       = 1'b0;
      redirect.strobe = 1'b1;
      redirect.target = r.target;
      model_pc        = r.target;
      @(posedge clk);
      #1;
      redirect = '0;
      @(negedge clk);
      if (pkg_valid !== 1'b0)
      begin
        errors++;
        $display("%s: packet valid still high the cycle after the redirect", r.name);
      end
      if (imem_req !== 1'b1)
      begin
        errors++;
        $display("%s: no fetch issued the cycle after the redirect", r.name);
      end
      check_addr(r.name, {r.target[31:3], 3'b000}, imem_addr);
    end
    while (got < r.count)
    begin
      @(posedge clk);
      #1;
      case (r.mode)
        RDY_ALWAYS: pkg_ready = 1'b1;
        RDY_RANDOM: pkg_ready = 1'($urandom % 2);
        default:    pkg_ready = (cyc >= HOLD_CYCLES);
      endcase
      @(negedge clk);
      if (r.mode == RDY_HOLD && cyc >= 8 && cyc < HOLD_CYCLES && !pkg_valid)
      begin
        errors++;
        $display("%s: valid dropped while ready was held low", r.name);
      end
      if (pkg_valid && pkg_ready)
      begin
        exp      = expect_pkt(model_pc);
        act.p    = pkg;
        act.mask = pkg_mask;
        check_mask($sformatf("%s[%0d]", r.name, got), exp.mask, act.mask);
        check_pkt($sformatf("%s[%0d]", r.name, got), exp, act);
        model_pc = {model_pc[31:3], 3'b000} + 32'd8;
        got++;
      end
      cyc++;
    end
    $display("test %s: %0d packets, %0d errors", r.name, got, errors - err_start);
  endtask

  initial
  begin
    clk        = 1'b0;
    arst_n_i   = 1'b0;
    redirect   = '0;
    imem_rdata = '0;
    pkg_ready  = 1'b0;
    req_s      = 1'b0;
    addr_s     = '0;
    checks     = 0;
    errors     = 0;
    void'($urandom(32'h138021d3));
    load_program();
    fill_table();
    model_pc = `FE_RESET_PC;
    repeat (16) @(posedge clk);
    #1;
    if (imem_req !== 1'b0 || pkg_valid !== 1'b0)
    begin
      errors++;
      $display("fetch strobe or packet valid high during reset");
    end
    arst_n_i = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(rows[i]);
    $display("%0d tests, %0d checks, %0d errors", NUM_ROWS, checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // limit grows with the packet count of every row
  initial
  begin : watchdog
    int limit;
    int cycles;
    @(posedge clk);
    limit = 200;
    for (int i = 0; i < NUM_ROWS; i++)
      limit += 40 * rows[i].count;
    cycles = 1;
    while (cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, packets stopped arriving", cycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* source/fe_align.sv */
`timescale 1ns/1ps

module fe_align (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   keep_i,
  input  logic [31:0]            pc_i,
  input  logic [1:0]             mask_i,
  input  logic [63:0]            rdata_i,
  output logic                   grp_valid_o,
  output fe_pipe_pkg::fetch_grp_t grp_o
);
  import fe_pipe_pkg::*;

  logic [31:0] pc_d;
  logic [1:0]  mask_d;
  fetch_grp_t  grp_d;
  fetch_grp_t  grp_q;
  logic        valid_q;

  // request info lines up with the memory data one cycle later
  always_ff @(posedge clk)
  begin
    pc_d   <= pc_i;
    mask_d <= mask_i;
  end

  always_comb
  begin
    grp_d.pc   = pc_d;
    grp_d.inst = rdata_i;
    grp_d.mask = mask_d;
    if (pc_d[2])
      grp_d.inst[0] = rdata_i[63:32];
  end

  always_ff @(posedge clk)
  begin
    if (keep_i)
      grp_q <= grp_d;
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      valid_q <= 1'b0;
    else
      valid_q <= keep_i;
  end

  assign grp_valid_o = valid_q;
  assign grp_o       = grp_q;

endmodule

/* source/fe_ctrl.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module fe_ctrl (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 redirect_strobe_i,
  input  logic [`FE_CNT_W-1:0] count_i,
  output logic                 fetch_o,
  output logic                 keep_o,
  output logic                 flush_o
);
  import fe_pipe_pkg::*;

  fe_state_e          state_q;
  fe_state_e          state_d;
  logic [1:0]         inflight_q;
  logic [`FE_CNT_W:0] used_w;
  logic               credit_ok;

  // bit 0 has data on the bus, bit 1 sits in the aligner
  assign used_w    = count_i + inflight_q[0] + inflight_q[1];
  assign credit_ok = used_w < (`FE_CNT_W + 1)'(`FE_FIFO_DEPTH);

  assign fetch_o = (state_q != ST_BOOT) && credit_ok && !redirect_strobe_i;
  assign keep_o  = inflight_q[0] && !redirect_strobe_i;
  assign flush_o = redirect_strobe_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_BOOT:
      begin
        state_d = ST_RUN;
      end
      ST_RUN:
      begin
        if (!credit_ok)
          state_d = ST_FULL;
      end
      default:
      begin
        if (credit_ok)
          state_d = ST_RUN;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q    <= ST_BOOT;
      inflight_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      // a redirect kills both groups still on their way
      inflight_q <= {inflight_q[0] && !redirect_strobe_i, fetch_o};
    end
  end

endmodule

/* source/fe_decoder.sv */
`timescale 1ns/1ps

module fe_decoder (
  input  logic [31:0]              inst_i,
  output fe_isa_pkg::decode_info_t info_o,
  output fe_isa_pkg::reg_info_t    regs_o,
  output logic                     ine_o
);
  import fe_isa_pkg::*;

  // opcode fields
  always_comb
  begin
    info_o = '{OP_INE, R0_NONE, R1_NONE, W_NONE};
    if (inst_i[31:15] == 17'h00020)
      info_o = '{OP_ADD_W, R0_RK, R1_RJ, W_RD};
    else if (inst_i[31:15] == 17'h00022)
      info_o = '{OP_SUB_W, R0_RK, R1_RJ, W_RD};
    else if (inst_i[31:22] == 10'h00a)
      info_o = '{OP_ADDI_W, R0_NONE, R1_RJ, W_RD};
    else if (inst_i[31:22] == 10'h0a2)
      info_o = '{OP_LD_W, R0_NONE, R1_RJ, W_RD};
    else if (inst_i[31:22] == 10'h0a6)
      info_o = '{OP_ST_W, R0_RD, R1_RJ, W_NONE};
    else if (inst_i[31:25] == 7'h0a)
      info_o = '{OP_LU12I_W, R0_NONE, R1_NONE, W_RD};
    else if (inst_i[31:26] == 6'h16)
      info_o = '{OP_BEQ, R0_RD, R1_RJ, W_NONE};
    else if (inst_i[31:26] == 6'h15)
      info_o = '{OP_BL, R0_NONE, R1_NONE, W_R1};
    else if (inst_i[31:26] == 6'h13)
      info_o = '{OP_JIRL, R0_NONE, R1_RJ, W_RD};
  end

  // register numbers from the selections
  always_comb
  begin
    case (info_o.r0_sel)
      R0_RK:   regs_o.r_reg[0] = inst_i[14:10];
      R0_RD:   regs_o.r_reg[0] = inst_i[4:0];
      default: regs_o.r_reg[0] = '0;
    endcase
    case (info_o.r1_sel)
      R1_RJ:   regs_o.r_reg[1] = inst_i[9:5];
      default: regs_o.r_reg[1] = '0;
    endcase
    case (info_o.w_sel)
      W_RD:    regs_o.w_reg = inst_i[4:0];
      W_R1:    regs_o.w_reg = 5'd1;
      default: regs_o.w_reg = '0;
    endcase
  end

  assign ine_o = (info_o.op == OP_INE);

endmodule

/* source/fe_isa_pkg.sv */
package fe_isa_pkg;

  typedef enum logic [3:0] {
    OP_ADD_W,
    OP_SUB_W,
    OP_ADDI_W,
    OP_LU12I_W,
    OP_LD_W,
    OP_ST_W,
    OP_BEQ,
    OP_BL,
    OP_JIRL,
    OP_INE
  } fe_op_e;

  // read port 0 source
  typedef enum logic [1:0] {
    R0_NONE,
    R0_RK,
    R0_RD
  } fe_r0_sel_e;

  // read port 1 source
  typedef enum logic {
    R1_NONE,
    R1_RJ
  } fe_r1_sel_e;

  // write port target, r1 is the link register of BL
  typedef enum logic [1:0] {
    W_NONE,
    W_RD,
    W_R1
  } fe_w_sel_e;

  typedef struct packed {
    fe_op_e     op;
    fe_r0_sel_e r0_sel;
    fe_r1_sel_e r1_sel;
    fe_w_sel_e  w_sel;
  } decode_info_t;

  typedef struct packed {
    logic [1:0][4:0] r_reg;
    logic [4:0]      w_reg;
  } reg_info_t;

endpackage

/* source/fe_pcgen.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module fe_pcgen (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        fetch_i,
  input  logic        flush_i,
  input  logic [31:0] target_i,
  output logic [31:0] fetch_addr_o,
  output logic [31:0] pc_o,
  output logic [1:0]  mask_o
);

  logic [31:0] pc_q;
  logic [31:0] base_w;

  assign base_w = {pc_q[31:3], 3'b000};

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pc_q <= `FE_RESET_PC;
    else if (flush_i)
      pc_q <= target_i;
    else if (fetch_i)
      pc_q <= base_w + 32'd8;
  end

  assign fetch_addr_o = base_w;
  assign pc_o         = pc_q;
  // upper word only, slot 0 after alignment
  assign mask_o = pc_q[2] ? 2'b01 : 2'b11;

endmodule

/* source/fe_pipe_pkg.sv */
package fe_pipe_pkg;

  // aligned fetch group, slot 0 always holds the first wanted word
  typedef struct packed {
    logic [31:0]      pc;
    logic [1:0][31:0] inst;
    logic [1:0]       mask;
  } fetch_grp_t;

  typedef struct packed {
    logic [31:0]              pc;
    fe_isa_pkg::decode_info_t di;
    fe_isa_pkg::reg_info_t    ri;
    logic                     ine;
  } pipeline_ctrl_pack_t;

  // queue entry
  typedef struct packed {
    pipeline_ctrl_pack_t [1:0] p;
    logic [1:0]                mask;
  } fe_pkt_t;

  typedef struct packed {
    logic        strobe;
    logic [31:0] target;
  } redirect_t;

  typedef enum logic [1:0] {
    ST_BOOT,
    ST_RUN,
    ST_FULL
  } fe_state_e;

endpackage

/* source/fe_pkg_fifo.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module fe_pkg_fifo (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 flush_i,
  input  logic                 push_i,
  input  fe_pipe_pkg::fe_pkt_t push_data_i,
  output logic                 pop_valid_o,
  input  logic                 pop_ready_i,
  output fe_pipe_pkg::fe_pkt_t pop_data_o,
  output logic [`FE_CNT_W-1:0] count_o
);
  import fe_pipe_pkg::*;

  localparam int DEPTH = `FE_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  fe_pkt_t              mem [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [`FE_CNT_W-1:0] cnt_q;
  logic                 push_ok;
  logic                 pop_ok;

  assign push_ok = push_i && (cnt_q < `FE_CNT_W'(DEPTH));
  assign pop_ok  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk)
  begin
    if (push_ok)
      mem[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else if (flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_ok)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_q + `FE_CNT_W'(push_ok) - `FE_CNT_W'(pop_ok);
    end
  end

  assign pop_valid_o = (cnt_q != '0);
  assign pop_data_o  = mem[rd_ptr_q];
  assign count_o     = cnt_q;

endmodule

/* source/fe_settings.svh */
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// program counter after reset
`define FE_RESET_PC 32'h1c000000

// packet queue depth, power of two
`define FE_FIFO_DEPTH 4

// queue occupancy width, holds 0 to depth
`define FE_CNT_W ($clog2(`FE_FIFO_DEPTH) + 1)

`endif

/* source/frontend.sv */
`timescale 1ns/1ps
`include "fe_settings.svh"

module frontend (
  input  logic                                 clk,
  input  logic                                 arst_n_i,
  input  fe_pipe_pkg::redirect_t               redirect_i,
  output logic                                 imem_req_o,
  output logic [31:0]                          imem_addr_o,
  input  logic [63:0]                          imem_rdata_i,
  output logic                                 pkg_valid_o,
  input  logic                                 pkg_ready_i,
  output logic [1:0]                           pkg_mask_o,
  output fe_pipe_pkg::pipeline_ctrl_pack_t [1:0] pkg_o
);
  import fe_isa_pkg::*;
  import fe_pipe_pkg::*;

  logic                 fetch;
  logic                 keep;
  logic                 flush;
  logic [31:0]          pc;
  logic [1:0]           mask;
  logic                 grp_valid;
  fetch_grp_t           grp;
  decode_info_t         info_w [2];
  reg_info_t            regs_w [2];
  logic [1:0]           ine_w;
  fe_pkt_t              push_pkt;
  fe_pkt_t              pop_pkt;
  logic [`FE_CNT_W-1:0] fifo_cnt;

  fe_ctrl i_ctrl (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .redirect_strobe_i (redirect_i.strobe),
    .count_i           (fifo_cnt),
    .fetch_o           (fetch),
    .keep_o            (keep),
    .flush_o           (flush)
  );

  fe_pcgen i_pcgen (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .fetch_i      (fetch),
    .flush_i      (flush),
    .target_i     (redirect_i.target),
    .fetch_addr_o (imem_addr_o),
    .pc_o         (pc),
    .mask_o       (mask)
  );

  assign imem_req_o = fetch;

  fe_align i_align (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .keep_i      (keep),
    .pc_i        (pc),
    .mask_i      (mask),
    .rdata_i     (imem_rdata_i),
    .grp_valid_o (grp_valid),
    .grp_o       (grp)
  );

  for (genvar i = 0; i < 2; i++)
  begin : gen_dec
    fe_decoder i_decoder (
      .inst_i (grp.inst[i]),
      .info_o (info_w[i]),
      .regs_o (regs_w[i]),
      .ine_o  (ine_w[i])
    );
  end

  // one packet per group, slot pc steps by a word
  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      push_pkt.p[i].pc  = grp.pc + 32'(4 * i);
      push_pkt.p[i].di  = info_w[i];
      push_pkt.p[i].ri  = regs_w[i];
      push_pkt.p[i].ine = ine_w[i];
    end
    push_pkt.mask = grp.mask;
  end

  fe_pkg_fifo i_pkg_fifo (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .flush_i     (flush),
    .push_i      (grp_valid),
    .push_data_i (push_pkt),
    .pop_valid_o (pkg_valid_o),
    .pop_ready_i (pkg_ready_i),
    .pop_data_o  (pop_pkt),
    .count_o     (fifo_cnt)
  );

  assign pkg_o      = pop_pkt.p;
  assign pkg_mask_o = pop_pkt.mask;

endmodule
